// ==== include/vec_cfg.svh ====
// Configuration macros for the vector unit
// Lane count, register file shape, queue depth and element width

`ifndef VEC_CFG_SVH
`define VEC_CFG_SVH

// Legal configurations:
//   all five values are powers of two
//   VEC_NR_LANES >= 2 and VEC_ELEMS_PER_LANE >= 2
//   VEC_ELEMS_PER_LANE >= VEC_QUEUE_DEPTH, so the queue cannot overflow
//   VEC_ELEN >= log2(VEC_NR_LANES * VEC_ELEMS_PER_LANE)

`define VEC_NR_LANES       4
`define VEC_ELEMS_PER_LANE 4
`define VEC_NR_VREGS       8
`define VEC_QUEUE_DEPTH    4
`define VEC_ELEN           16

`endif

// ==== hw/vec_pkg.sv ====
// Shared types of the vector unit
// Element, index and opcode types, sequencer states

`include "vec_cfg.svh"

package vec_pkg;

  // One vector element
  typedef logic [`VEC_ELEN-1:0] elen_t;

  // Vector register number
  typedef logic [$clog2(`VEC_NR_VREGS)-1:0] vreg_idx_t;

  // Element slot inside one lane
  typedef logic [$clog2(`VEC_ELEMS_PER_LANE)-1:0] slot_idx_t;

  // Global element index across all lanes
  typedef logic [$clog2(`VEC_NR_LANES*`VEC_ELEMS_PER_LANE)-1:0] elem_idx_t;

  // Instruction opcodes, codes 6 and 7 are illegal
  typedef enum logic [2:0] {
    VADD_VV = 3'd0,
    VSUB_VV = 3'd1,
    VAND_VV = 3'd2,
    VXOR_VV = 3'd3,
    VMV_VX  = 3'd4,
    VRD_X   = 3'd5
  } vop_e;

  // Sequencer states
  typedef enum logic [1:0] {
    SEQ_IDLE = 2'd0,
    SEQ_EXEC = 2'd1,
    SEQ_READ = 2'd2
  } seq_state_e;

endpackage

// ==== hw/vec_dispatcher.sv ====
// Instruction dispatcher
// Checks each host strobe, acknowledges it and pushes legal instructions

`timescale 1ns/1ps

`include "vec_cfg.svh"

module vec_dispatcher (
  input  logic               clk_i,
  input  logic               reset_i,
  // Host strobe
  input  logic               acc_valid_i,
  input  vec_pkg::vop_e      acc_op_i,
  input  vec_pkg::vreg_idx_t acc_vd_i,
  input  vec_pkg::vreg_idx_t acc_vs1_i,
  input  vec_pkg::vreg_idx_t acc_vs2_i,
  input  vec_pkg::elen_t     acc_scalar_i,
  // Instruction queue
  input  logic               queue_full_i,
  output logic               push_o,
  output vec_pkg::vop_e      push_op_o,
  output vec_pkg::vreg_idx_t push_vd_o,
  output vec_pkg::vreg_idx_t push_vs1_o,
  output vec_pkg::vreg_idx_t push_vs2_o,
  output vec_pkg::elen_t     push_scalar_o,
  // Acknowledgement
  output logic               ack_valid_o,
  output logic               ack_ok_o
);

  import vec_pkg::*;

  localparam int unsigned NrElems = `VEC_NR_LANES * `VEC_ELEMS_PER_LANE;

  logic op_legal;
  logic idx_legal;
  logic accept;

  logic ack_valid_q;
  logic ack_ok_q;
  logic push_q;

  // Decode against the acceptance rule
  always_comb begin
    unique case (acc_op_i)
      VADD_VV, VSUB_VV, VAND_VV, VXOR_VV, VMV_VX, VRD_X: op_legal = 1'b1;
      default: op_legal = 1'b0;
    endcase
  end

  // Read index must address an existing element
  assign idx_legal = (acc_op_i != VRD_X) || (acc_scalar_i < elen_t'(NrElems));

  // Full already counts the push still in flight from the previous cycle
  assign accept = acc_valid_i && op_legal && idx_legal && !queue_full_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_valid_q <= 1'b0;
      ack_ok_q    <= 1'b0;
      push_q      <= 1'b0;
    end else begin
      ack_valid_q <= acc_valid_i;
      ack_ok_q    <= accept;
      push_q      <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      push_op_o     <= acc_op_i;
      push_vd_o     <= acc_vd_i;
      push_vs1_o    <= acc_vs1_i;
      push_vs2_o    <= acc_vs2_i;
      push_scalar_o <= acc_scalar_i;
    end
  end

  assign push_o      = push_q;
  assign ack_valid_o = ack_valid_q;
  assign ack_ok_o    = ack_ok_q;

endmodule

// ==== hw/vec_insn_queue.sv ====
// Instruction queue
// Circular FIFO of accepted instructions with occupancy count

`timescale 1ns/1ps

`include "vec_cfg.svh"

module vec_insn_queue (
  input  logic               clk_i,
  input  logic               reset_i,
  // Push side
  input  logic               push_i,
  input  vec_pkg::vop_e      push_op_i,
  input  vec_pkg::vreg_idx_t push_vd_i,
  input  vec_pkg::vreg_idx_t push_vs1_i,
  input  vec_pkg::vreg_idx_t push_vs2_i,
  input  vec_pkg::elen_t     push_scalar_i,
  // Pop side
  input  logic               pop_i,
  output vec_pkg::vop_e      head_op_o,
  output vec_pkg::vreg_idx_t head_vd_o,
  output vec_pkg::vreg_idx_t head_vs1_o,
  output vec_pkg::vreg_idx_t head_vs2_o,
  output vec_pkg::elen_t     head_scalar_o,
  // Status
  output logic               empty_o,
  output logic               full_o
);

  import vec_pkg::*;

  localparam int unsigned Depth = `VEC_QUEUE_DEPTH;
  localparam int unsigned PtrW  = $clog2(Depth);

  vop_e      op_mem     [Depth];
  vreg_idx_t vd_mem     [Depth];
  vreg_idx_t vs1_mem    [Depth];
  vreg_idx_t vs2_mem    [Depth];
  elen_t     scalar_mem [Depth];

  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [PtrW:0]   count_q;

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_i)  rd_ptr_q <= rd_ptr_q + 1'b1;
      unique case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      op_mem[wr_ptr_q]     <= push_op_i;
      vd_mem[wr_ptr_q]     <= push_vd_i;
      vs1_mem[wr_ptr_q]    <= push_vs1_i;
      vs2_mem[wr_ptr_q]    <= push_vs2_i;
      scalar_mem[wr_ptr_q] <= push_scalar_i;
    end
  end

  assign head_op_o     = op_mem[rd_ptr_q];
  assign head_vd_o     = vd_mem[rd_ptr_q];
  assign head_vs1_o    = vs1_mem[rd_ptr_q];
  assign head_vs2_o    = vs2_mem[rd_ptr_q];
  assign head_scalar_o = scalar_mem[rd_ptr_q];

  assign empty_o = (count_q == '0);
  // Includes the push landing at the next edge, ignores a concurrent pop
  assign full_o  = (32'(count_q) + 32'(push_i)) >= Depth;

endmodule

// ==== hw/vec_sequencer.sv ====
// Instruction sequencer
// Pops instructions, steps element slots across the lanes, returns reads

`timescale 1ns/1ps

`include "vec_cfg.svh"

module vec_sequencer (
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  // Queue head
  input  vec_pkg::vop_e                           head_op_i,
  input  vec_pkg::vreg_idx_t                      head_vd_i,
  input  vec_pkg::vreg_idx_t                      head_vs1_i,
  input  vec_pkg::vreg_idx_t                      head_vs2_i,
  input  vec_pkg::elen_t                          head_scalar_i,
  input  logic                                    empty_i,
  output logic                                    pop_o,
  // Broadcast to the lanes
  output logic                                    exec_o,
  output vec_pkg::vop_e                           exec_op_o,
  output vec_pkg::vreg_idx_t                      exec_vd_o,
  output vec_pkg::vreg_idx_t                      exec_vs1_o,
  output vec_pkg::vreg_idx_t                      exec_vs2_o,
  output vec_pkg::slot_idx_t                      exec_slot_o,
  output vec_pkg::elen_t                          exec_scalar_o,
  input  vec_pkg::elen_t [`VEC_NR_LANES-1:0]      lane_rdata_i,
  // Read result to the host
  output logic                                    rd_valid_o,
  output vec_pkg::elen_t                          rd_data_o
);

  import vec_pkg::*;

  localparam int unsigned LaneW = $clog2(`VEC_NR_LANES);
  localparam int unsigned ElemW = $bits(elem_idx_t);

  seq_state_e state_q;
  slot_idx_t  slot_q;

  vop_e             op_q;
  vreg_idx_t        vd_q;
  vreg_idx_t        vs1_q;
  vreg_idx_t        vs2_q;
  elen_t            scalar_q;
  logic [LaneW-1:0] lane_q;

  elem_idx_t head_idx;

  // Element e sits in lane e mod NrLanes at slot e div NrLanes
  assign head_idx = head_scalar_i[ElemW-1:0];

  assign pop_o = (state_q == SEQ_IDLE) && !empty_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= SEQ_IDLE;
      slot_q  <= '0;
    end else begin
      unique case (state_q)
        SEQ_IDLE: begin
          if (pop_o) begin
            if (head_op_i == VRD_X) begin
              state_q <= SEQ_READ;
              slot_q  <= head_idx[ElemW-1:LaneW];
            end else begin
              state_q <= SEQ_EXEC;
              slot_q  <= '0;
            end
          end
        end
        SEQ_EXEC: begin
          // One slot per edge in every lane
          slot_q <= slot_q + 1'b1;
          if (slot_q == slot_idx_t'(`VEC_ELEMS_PER_LANE - 1)) begin
            state_q <= SEQ_IDLE;
          end
        end
        SEQ_READ: state_q <= SEQ_IDLE;
        default:  state_q <= SEQ_IDLE;
      endcase
    end
  end

  // Latch the popped instruction
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      op_q     <= head_op_i;
      vd_q     <= head_vd_i;
      vs1_q    <= head_vs1_i;
      vs2_q    <= head_vs2_i;
      scalar_q <= head_scalar_i;
      lane_q   <= head_idx[LaneW-1:0];
    end
  end

  assign exec_o        = (state_q == SEQ_EXEC);
  assign exec_op_o     = op_q;
  assign exec_vd_o     = vd_q;
  assign exec_vs1_o    = vs1_q;
  assign exec_vs2_o    = vs2_q;
  assign exec_slot_o   = slot_q;
  assign exec_scalar_o = scalar_q;

  // For reads the lanes show vs2 at the selected slot
  assign rd_valid_o = (state_q == SEQ_READ);
  assign rd_data_o  = lane_rdata_i[lane_q];

endmodule

// ==== hw/vec_lane.sv ====
// Vector lane
// Register file slice and element ALU of one lane

`timescale 1ns/1ps

`include "vec_cfg.svh"

module vec_lane (
  input  logic               clk_i,
  input  logic               reset_i,
  // Broadcast from the sequencer
  input  logic               exec_i,
  input  vec_pkg::vop_e      exec_op_i,
  input  vec_pkg::vreg_idx_t exec_vd_i,
  input  vec_pkg::vreg_idx_t exec_vs1_i,
  input  vec_pkg::vreg_idx_t exec_vs2_i,
  input  vec_pkg::slot_idx_t exec_slot_i,
  input  vec_pkg::elen_t     exec_scalar_i,
  // Element of vs2 at the current slot
  output vec_pkg::elen_t     rdata_o
);

  import vec_pkg::*;

  // Register file slice, one row per vector register
  elen_t vrf_q [`VEC_NR_VREGS][`VEC_ELEMS_PER_LANE];

  elen_t op_a;
  elen_t op_b;
  elen_t result;
  logic  wr_en;

  assign op_a = vrf_q[exec_vs1_i][exec_slot_i];
  assign op_b = vrf_q[exec_vs2_i][exec_slot_i];

  // Element ALU, add and subtract wrap at the element width
  always_comb begin
    unique case (exec_op_i)
      VADD_VV: result = op_a + op_b;
      VSUB_VV: result = op_a - op_b;
      VAND_VV: result = op_a & op_b;
      VXOR_VV: result = op_a ^ op_b;
      VMV_VX:  result = exec_scalar_i;
      default: result = op_b;
    endcase
  end

  // Reads never write back
  assign wr_en = exec_i && (exec_op_i != VRD_X);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      vrf_q <= '{default: '0};
    end else if (wr_en) begin
      vrf_q[exec_vd_i][exec_slot_i] <= result;
    end
  end

  assign rdata_o = op_b;

endmodule

// ==== hw/vec_unit.sv ====
// Vector unit top level
// Dispatcher, instruction queue, sequencer and the lane array

`timescale 1ns/1ps

`include "vec_cfg.svh"

module vec_unit (
  input  logic               clk_i,
  input  logic               reset_i,
  // Host strobe
  input  logic               acc_valid_i,
  input  vec_pkg::vop_e      acc_op_i,
  input  vec_pkg::vreg_idx_t acc_vd_i,
  input  vec_pkg::vreg_idx_t acc_vs1_i,
  input  vec_pkg::vreg_idx_t acc_vs2_i,
  input  vec_pkg::elen_t     acc_scalar_i,
  // Host responses
  output logic               ack_valid_o,
  output logic               ack_ok_o,
  output logic               rd_valid_o,
  output vec_pkg::elen_t     rd_data_o
);

  import vec_pkg::*;

  // Dispatcher to queue
  logic      push;
  vop_e      push_op;
  vreg_idx_t push_vd;
  vreg_idx_t push_vs1;
  vreg_idx_t push_vs2;
  elen_t     push_scalar;
  logic      queue_full;

  // Queue to sequencer
  vop_e      head_op;
  vreg_idx_t head_vd;
  vreg_idx_t head_vs1;
  vreg_idx_t head_vs2;
  elen_t     head_scalar;
  logic      queue_empty;
  logic      pop;

  // Sequencer to lanes
  logic                          exec;
  vop_e                          exec_op;
  vreg_idx_t                     exec_vd;
  vreg_idx_t                     exec_vs1;
  vreg_idx_t                     exec_vs2;
  slot_idx_t                     exec_slot;
  elen_t                         exec_scalar;
  elen_t [`VEC_NR_LANES-1:0]     lane_rdata;

  vec_dispatcher i_dispatcher (
    .clk_i        (clk_i       ),
    .reset_i      (reset_i     ),
    .acc_valid_i  (acc_valid_i ),
    .acc_op_i     (acc_op_i    ),
    .acc_vd_i     (acc_vd_i    ),
    .acc_vs1_i    (acc_vs1_i   ),
    .acc_vs2_i    (acc_vs2_i   ),
    .acc_scalar_i (acc_scalar_i),
    .queue_full_i (queue_full  ),
    .push_o       (push        ),
    .push_op_o    (push_op     ),
    .push_vd_o    (push_vd     ),
    .push_vs1_o   (push_vs1    ),
    .push_vs2_o   (push_vs2    ),
    .push_scalar_o(push_scalar ),
    .ack_valid_o  (ack_valid_o ),
    .ack_ok_o     (ack_ok_o    )
  );

  vec_insn_queue i_insn_queue (
    .clk_i        (clk_i      ),
    .reset_i      (reset_i    ),
    .push_i       (push       ),
    .push_op_i    (push_op    ),
    .push_vd_i    (push_vd    ),
    .push_vs1_i   (push_vs1   ),
    .push_vs2_i   (push_vs2   ),
    .push_scalar_i(push_scalar),
    .pop_i        (pop        ),
    .head_op_o    (head_op    ),
    .head_vd_o    (head_vd    ),
    .head_vs1_o   (head_vs1   ),
    .head_vs2_o   (head_vs2   ),
    .head_scalar_o(head_scalar),
    .empty_o      (queue_empty),
    .full_o       (queue_full )
  );

  vec_sequencer i_sequencer (
    .clk_i        (clk_i      ),
    .reset_i      (reset_i    ),
    .head_op_i    (head_op    ),
    .head_vd_i    (head_vd    ),
    .head_vs1_i   (head_vs1   ),
    .head_vs2_i   (head_vs2   ),
    .head_scalar_i(head_scalar),
    .empty_i      (queue_empty),
    .pop_o        (pop        ),
    .exec_o       (exec       ),
    .exec_op_o    (exec_op    ),
    .exec_vd_o    (exec_vd    ),
    .exec_vs1_o   (exec_vs1   ),
    .exec_vs2_o   (exec_vs2   ),
    .exec_slot_o  (exec_slot  ),
    .exec_scalar_o(exec_scalar),
    .lane_rdata_i (lane_rdata ),
    .rd_valid_o   (rd_valid_o ),
    .rd_data_o    (rd_data_o  )
  );

  // All lanes see the same broadcast
  for (genvar lane = 0; lane < `VEC_NR_LANES; lane++) begin : gen_lanes
    vec_lane i_lane (
      .clk_i        (clk_i           ),
      .reset_i      (reset_i         ),
      .exec_i       (exec            ),
      .exec_op_i    (exec_op         ),
      .exec_vd_i    (exec_vd         ),
      .exec_vs1_i   (exec_vs1        ),
      .exec_vs2_i   (exec_vs2        ),
      .exec_slot_i  (exec_slot       ),
      .exec_scalar_i(exec_scalar     ),
      .rdata_o      (lane_rdata[lane])
    );
  end : gen_lanes

endmodule

// ==== dv/vec_unit_tb.sv ====
// Testbench for the vector unit
// Row table, register model, check tasks and watchdog

`timescale 1ns/1ps

`include "vec_cfg.svh"

module vec_unit_tb;

  import vec_pkg::*;

  localparam int NrElems = `VEC_NR_LANES * `VEC_ELEMS_PER_LANE;

  // One table row: instruction, idle gap after it, expected responses
  typedef struct packed {
    logic [2:0] op;
    vreg_idx_t  vd;
    vreg_idx_t  vs1;
    vreg_idx_t  vs2;
    elen_t      scalar;
    logic       rand_scalar;
    logic [7:0] gap;
    logic       exp_ok;
    logic       exp_fixed;
    elen_t      exp_val;
  } row_t;

  logic      clk_i;
  logic      reset_i;
  logic      acc_valid_i;
  vop_e      acc_op_i;
  vreg_idx_t acc_vd_i;
  vreg_idx_t acc_vs1_i;
  vreg_idx_t acc_vs2_i;
  elen_t     acc_scalar_i;
  logic      ack_valid_o;
  logic      ack_ok_o;
  logic      rd_valid_o;
  elen_t     rd_data_o;

  row_t        rows[$];
  elen_t       exp_rd[$];
  elen_t       model [`VEC_NR_VREGS][NrElems];
  logic [31:0] lcg_state;
  int unsigned watchdog_cycles;

  vec_unit DUT (
    .clk_i       (clk_i       ),
    .reset_i     (reset_i     ),
    .acc_valid_i (acc_valid_i ),
    .acc_op_i    (acc_op_i    ),
    .acc_vd_i    (acc_vd_i    ),
    .acc_vs1_i   (acc_vs1_i   ),
    .acc_vs2_i   (acc_vs2_i   ),
    .acc_scalar_i(acc_scalar_i),
    .ack_valid_o (ack_valid_o ),
    .ack_ok_o    (ack_ok_o    ),
    .rd_valid_o  (rd_valid_o  ),
    .rd_data_o   (rd_data_o   )
  );

  always #10 clk_i = ~clk_i;

  task automatic stop_on_error();
    $display("Done: errors found");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_ack(input logic exp_ok);
    if (ack_valid_o !== 1'b1) begin
      $display("No acknowledgement one cycle after the strobe, time %0t", $time);
      stop_on_error();
    end else if (ack_ok_o !== exp_ok) begin
      $display("Error at %0t: ack_ok_o is %b, expected %b", $time, ack_ok_o, exp_ok);
      stop_on_error();
    end
  endtask

  task automatic check_rdata(input elen_t exp_data);
    if (rd_data_o !== exp_data) begin
      $display("Error at %0t: rd_data_o is %h, expected %h", $time, rd_data_o, exp_data);
      stop_on_error();
    end
  endtask

  function automatic elen_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return elen_t'(lcg_state[31:16]);
  endfunction

  task automatic add_row(input logic [2:0] op, input int vd, input int vs1, input int vs2,
                         input elen_t scalar, input logic rnd, input int gap,
                         input logic ok);
    row_t r;
    r = '0;
    r.op          = op;
    r.vd          = vreg_idx_t'(vd);
    r.vs1         = vreg_idx_t'(vs1);
    r.vs2         = vreg_idx_t'(vs2);
    r.scalar      = scalar;
    r.rand_scalar = rnd;
    r.gap         = 8'(gap);
    r.exp_ok      = ok;
    rows.push_back(r);
  endtask

  // Reads take the register from vs2 and the element index from the scalar
  task automatic add_read(input int vs2, input int idx, input int gap, input logic fixed,
                          input elen_t val);
    row_t r;
    r = '0;
    r.op        = VRD_X;
    r.vs2       = vreg_idx_t'(vs2);
    r.scalar    = elen_t'(idx);
    r.gap       = 8'(gap);
    r.exp_ok    = 1'b1;
    r.exp_fixed = fixed;
    r.exp_val   = val;
    rows.push_back(r);
  endtask

  task automatic build_table();
    // Registers come out of reset cleared
    add_read(5, 7, 2, 1, 16'h0000);
    // Known splats, then every lane and slot
    add_row(VMV_VX, 1, 0, 0, 16'h1234, 0, 4, 1);
    add_row(VMV_VX, 2, 0, 0, 16'hA5C3, 0, 4, 1);
    for (int e = 0; e < NrElems; e++) begin
      if (e % 2 == 0) add_read(1, e, 2, 1, 16'h1234);
      else add_read(2, e, 2, 1, 16'hA5C3);
    end
    // Arithmetic on random splats, last round forces an add and a subtract wrap
    for (int r = 0; r < 3; r++) begin
      add_row(VMV_VX, 0, 0, 0, 16'hF00F, r < 2, 4, 1);
      add_row(VMV_VX, 7, 0, 0, 16'h2345, r < 2, 4, 1);
      add_row(VADD_VV, 3, 0, 7, 0, 0, 4, 1);
      add_row(VSUB_VV, 4, (r != 0) ? 7 : 0, (r != 0) ? 0 : 7, 0, 0, 4, 1);
      add_row(VAND_VV, 5, 0, 7, 0, 0, 4, 1);
      add_row(VXOR_VV, 6, 0, 7, 0, 0, 4, 1);
      for (int k = 0; k < 4; k++) add_read(3 + k, (r * 5 + k * 3) % NrElems, 2, 0, 0);
    end
    // Illegal opcodes and out of range read index
    add_row(3'd6, 1, 0, 0, 16'hDEAD, 0, 4, 0);
    add_row(3'd7, 2, 1, 1, 16'hBEEF, 0, 4, 0);
    add_row(VRD_X, 0, 0, 1, 16'd16, 0, 4, 0);
    add_row(VRD_X, 0, 0, 2, 16'hFFFF, 0, 4, 0);
    add_read(1, 3, 2, 1, 16'h1234);
    add_read(2, 6, 10, 1, 16'hA5C3);
    // Back-to-back burst into an idle unit
    for (int k = 0; k < `VEC_QUEUE_DEPTH + 2; k++) begin
      add_row(VMV_VX, 3 + (k % 4), 0, 0, elen_t'(16'h0101 * (k + 1)), 0,
              (k == `VEC_QUEUE_DEPTH + 1) ? 30 : 0, k < `VEC_QUEUE_DEPTH + 1);
    end
    add_read(3, 15, 2, 1, 16'h0505);
    add_read(4, 9, 2, 1, 16'h0202);
    add_read(5, 4, 2, 0, 0);
    add_read(6, 2, 4, 0, 0);
    // Dependent instructions with no gap
    add_row(VADD_VV, 7, 1, 2, 0, 0, 0, 1);
    add_read(7, 10, 0, 1, 16'hB7F7);
    add_row(VXOR_VV, 7, 7, 1, 0, 0, 0, 1);
    add_read(7, 13, 4, 0, 0);
  endtask

  // Register model, element e of each register at index e
  task automatic update_model(input row_t r);
    if (r.op == VRD_X) begin
      if (r.exp_fixed) exp_rd.push_back(r.exp_val);
      else exp_rd.push_back(model[r.vs2][int'(r.scalar)]);
    end else begin
      for (int e = 0; e < NrElems; e++) begin
        case (r.op)
          VADD_VV: model[r.vd][e] = model[r.vs1][e] + model[r.vs2][e];
          VSUB_VV: model[r.vd][e] = model[r.vs1][e] - model[r.vs2][e];
          VAND_VV: model[r.vd][e] = model[r.vs1][e] & model[r.vs2][e];
          VXOR_VV: model[r.vd][e] = model[r.vs1][e] ^ model[r.vs2][e];
          VMV_VX:  model[r.vd][e] = r.scalar;
          default: ;
        endcase
      end
    end
  endtask

  // Read results, sampled away from the rising edge
  initial begin
    forever begin
      @(negedge clk_i);
      if (!reset_i && rd_valid_o) begin
        if (exp_rd.size() == 0) begin
          $display("Read result arrived with no read outstanding, time %0t", $time);
          stop_on_error();
        end else begin
          check_rdata(exp_rd.pop_front());
        end
      end
    end
  end

  initial begin
    row_t cur;
    clk_i        = 1'b0;
    reset_i      = 1'b1;
    acc_valid_i  = 1'b0;
    acc_op_i     = VADD_VV;
    acc_vd_i     = '0;
    acc_vs1_i    = '0;
    acc_vs2_i    = '0;
    acc_scalar_i = '0;
    lcg_state    = 32'h728d_6182;
    for (int v = 0; v < `VEC_NR_VREGS; v++) begin
      for (int e = 0; e < NrElems; e++) model[v][e] = '0;
    end
    build_table();
    watchdog_cycles = 100;
    foreach (rows[i]) watchdog_cycles += rows[i].gap + `VEC_ELEMS_PER_LANE + 4;
    fork
      begin
        repeat (watchdog_cycles) @(posedge clk_i);
        $display("Timeout: the run timed out waiting for results at %0t", $time);
        stop_on_error();
      end
    join_none
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    for (int i = 0; i < rows.size(); i++) begin
      cur = rows[i];
      if (cur.rand_scalar) cur.scalar = lcg_next();
      acc_valid_i  = 1'b1;
      acc_op_i     = vop_e'(cur.op);
      acc_vd_i     = cur.vd;
      acc_vs1_i    = cur.vs1;
      acc_vs2_i    = cur.vs2;
      acc_scalar_i = cur.scalar;
      @(negedge clk_i);
      check_ack(cur.exp_ok);
      acc_valid_i = 1'b0;
      if (cur.exp_ok) update_model(cur);
      // Acknowledgement lasts exactly one cycle
      for (int g = 0; g < cur.gap; g++) begin
        @(negedge clk_i);
        if (ack_valid_o !== 1'b0) begin
          $display("Acknowledgement without a strobe, time %0t", $time);
          stop_on_error();
        end
      end
    end
    // Drain outstanding reads
    while (exp_rd.size() != 0) @(negedge clk_i);
    repeat (4) @(negedge clk_i);
    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== vec_unit.f ====
+incdir+include
hw/vec_pkg.sv
hw/vec_dispatcher.sv
hw/vec_insn_queue.sv
hw/vec_sequencer.sv
hw/vec_lane.sv
hw/vec_unit.sv
dv/vec_unit_tb.sv
